// File: dma_defs.svh
// DMA control core constants
// Register map placement, bus widths and request size limits

`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

`define DMA_ADDR_WIDTH       16                     // Wishbone byte address
`define DMA_DATA_WIDTH       32                     // Wishbone data
`define DMA_SEL_WIDTH        (`DMA_DATA_WIDTH / 8)  // One select per byte lane
`define DMA_HOST_ADDR_WIDTH  32
`define DMA_SIZE_WIDTH       32                     // Descriptor size and request length

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

`define DMA_ENGINE_BASE      16'h0200
`define DMA_ENGINE_STRIDE    16'h2000
// Global register sits one engine block past the engine table
`define DMA_GLOBAL_ADDR      (`DMA_ENGINE_BASE + `DMA_ENGINE_STRIDE)

////////////////////////////////////////////////////////////////////////////
// Request limits, as log2 of bytes
////////////////////////////////////////////////////////////////////////////

`define DMA_LOG2_MAX_PAYLOAD       8   // Card to host requests
`define DMA_LOG2_MAX_READ_REQUEST  12  // Host to card requests

`endif

// File: dma_pkg.sv
// DMA control core types
// Engine register offsets, transfer direction and splitter states

`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

	// Byte offsets from the engine block base
	typedef enum logic [7:0] {
		REG_CONTROL   = 8'h00,  // bit0 start, bit1 direction
		REG_STATUS    = 8'h04,  // bit0 enabled, bit3 stopped
		REG_DESC_ADDR = 8'h08,
		REG_DESC_SIZE = 8'h0C,
		REG_REQ_COUNT = 8'h10   // Requests issued since start
	} reg_offset_e;

	typedef enum logic {
		DIR_READ  = 1'b0,  // Host to card
		DIR_WRITE = 1'b1   // Card to host
	} dir_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_DONE
	} split_state_e;

endpackage

`default_nettype wire

// File: dma_global_regs.sv
// DMA global register
// Reports payload and read-request capability codes and
// turns a write of bit 7 into a one-cycle engine soft reset

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_global_regs (
	input  logic                        CLK,
	input  logic                        dma_reset_n,
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  logic [`DMA_ADDR_WIDTH-1:0]  wb_adr,
	input  logic [`DMA_DATA_WIDTH-1:0]  wb_dat_i,
	input  logic [`DMA_SEL_WIDTH-1:0]   wb_sel,
	output logic                        ack,
	output logic [`DMA_DATA_WIDTH-1:0]  dat,
	output logic                        soft_reset_n
);

	localparam logic [`DMA_ADDR_WIDTH-1:0] ENGINE_LO   = `DMA_ENGINE_BASE;
	localparam logic [`DMA_ADDR_WIDTH-1:0] ENGINE_HI   = `DMA_ENGINE_BASE + `DMA_ENGINE_STRIDE;
	localparam logic [`DMA_ADDR_WIDTH-1:0] GLOBAL_ADDR = `DMA_GLOBAL_ADDR;

	// Capability codes are log2 of the limit minus 7
	localparam logic [2:0] PAYLOAD_CODE = 3'(`DMA_LOG2_MAX_PAYLOAD - 7);
	localparam logic [2:0] READ_REQ_CODE = 3'(`DMA_LOG2_MAX_READ_REQUEST - 7);

	logic in_engine;
	logic access;
	logic hit;
	logic [`DMA_DATA_WIDTH-1:0] cap_word;

	// Everything outside the engine block lands here, unmapped reads return zero
	assign in_engine = (wb_adr >= ENGINE_LO) && (wb_adr < ENGINE_HI);
	assign access    = wb_cyc & wb_stb & ~ack & ~in_engine;
	assign hit       = (wb_adr == GLOBAL_ADDR);
	assign cap_word  = {{(`DMA_DATA_WIDTH - 6){1'b0}}, READ_REQ_CODE, PAYLOAD_CODE};

	always_ff @(posedge CLK) begin
		if (!dma_reset_n) begin
			ack          <= 1'b0;
			soft_reset_n <= 1'b1;
		end else begin
			ack <= access;  // One cycle, never back to back
			soft_reset_n <= ~(access & wb_we & hit & wb_sel[0] & wb_dat_i[7]);
		end
	end

	// Read data, valid together with ack
	always_ff @(posedge CLK) begin
		if (access) begin
			dat <= hit ? cap_word : '0;
		end
	end

endmodule

`default_nettype wire

// File: dma_engine_regs.sv
// DMA engine register block
// Holds the descriptor and direction, issues the start pulse
// and reports enabled, stopped and the request count

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_engine_regs (
	input  logic                            CLK,
	input  logic                            engine_reset_n,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic [`DMA_ADDR_WIDTH-1:0]      wb_adr,
	input  logic [`DMA_DATA_WIDTH-1:0]      wb_dat_i,
	input  logic [`DMA_SEL_WIDTH-1:0]       wb_sel,
	input  logic                            busy,
	input  logic                            done,
	input  logic [`DMA_DATA_WIDTH-1:0]      req_count,
	output logic                            ack,
	output logic [`DMA_DATA_WIDTH-1:0]      dat,
	output logic                            start,
	output logic [`DMA_HOST_ADDR_WIDTH-1:0] desc_addr,
	output logic [`DMA_SIZE_WIDTH-1:0]      desc_size,
	output dma_pkg::dir_e                   desc_dir
);

	localparam logic [`DMA_ADDR_WIDTH-1:0] ENGINE_LO = `DMA_ENGINE_BASE;
	localparam logic [`DMA_ADDR_WIDTH-1:0] ENGINE_HI = `DMA_ENGINE_BASE + `DMA_ENGINE_STRIDE;

	logic [`DMA_ADDR_WIDTH-1:0] offset;
	logic [7:0] reg_sel;
	logic in_window;
	logic reg_hit;
	logic access;
	logic stopped;
	logic [`DMA_DATA_WIDTH-1:0] rd_mux;

	assign offset    = wb_adr - ENGINE_LO;
	assign reg_sel   = offset[7:0];
	assign in_window = (wb_adr >= ENGINE_LO) && (wb_adr < ENGINE_HI);
	assign reg_hit   = (offset[`DMA_ADDR_WIDTH-1:8] == '0);  // Registers live in the first 256 bytes
	assign access    = wb_cyc & wb_stb & ~ack & in_window;

	////////////////////////////////////////////////////////////////////////////
	// Register writes and control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!engine_reset_n) begin
			ack       <= 1'b0;
			start     <= 1'b0;
			stopped   <= 1'b0;
			desc_addr <= '0;
			desc_size <= '0;
			desc_dir  <= dma_pkg::DIR_READ;
		end else begin
			ack   <= access;
			start <= 1'b0;  // Single cycle pulse
			if (done)
				stopped <= 1'b1;
			else if (start)
				stopped <= 1'b0;
			if (access && wb_we && reg_hit) begin
				case (reg_sel)
					dma_pkg::REG_CONTROL: begin
						if (wb_sel[0]) begin
							desc_dir <= dma_pkg::dir_e'(wb_dat_i[1]);
							start    <= wb_dat_i[0] & ~busy;  // Ignored while running
						end
					end
					dma_pkg::REG_DESC_ADDR: begin
						for (int b = 0; b < `DMA_SEL_WIDTH; b++) begin
							if (wb_sel[b])
								desc_addr[8*b +: 8] <= wb_dat_i[8*b +: 8];
						end
					end
					dma_pkg::REG_DESC_SIZE: begin
						for (int b = 0; b < `DMA_SEL_WIDTH; b++) begin
							if (wb_sel[b])
								desc_size[8*b +: 8] <= wb_dat_i[8*b +: 8];
						end
					end
					default: ;  // Status and count are read only
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_mux = '0;
		if (reg_hit) begin
			case (reg_sel)
				dma_pkg::REG_CONTROL:   rd_mux[1] = desc_dir;
				dma_pkg::REG_STATUS:    rd_mux = {{(`DMA_DATA_WIDTH - 4){1'b0}}, stopped, 2'b00, busy};
				dma_pkg::REG_DESC_ADDR: rd_mux = desc_addr;
				dma_pkg::REG_DESC_SIZE: rd_mux = desc_size;
				dma_pkg::REG_REQ_COUNT: rd_mux = req_count;
				default:                rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (access)
			dat <= rd_mux;  // Sampled on the ack edge
	end

endmodule

`default_nettype wire

// File: dma_request_splitter.sv
// DMA request splitter
// Cuts a descriptor into requests no larger than the payload limit
// (card to host) or the read-request limit (host to card)

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_request_splitter (
	input  logic                            CLK,
	input  logic                            engine_reset_n,
	input  logic                            start,
	input  logic [`DMA_HOST_ADDR_WIDTH-1:0] desc_addr,
	input  logic [`DMA_SIZE_WIDTH-1:0]      desc_size,
	input  dma_pkg::dir_e                   desc_dir,
	input  logic                            req_ready,
	output logic                            req_valid,
	output logic [`DMA_HOST_ADDR_WIDTH-1:0] req_addr,
	output logic [`DMA_SIZE_WIDTH-1:0]      req_len,
	output dma_pkg::dir_e                   req_dir,
	output logic                            busy,
	output logic                            done,
	output logic [`DMA_DATA_WIDTH-1:0]      req_count
);

	localparam int HOST_W = `DMA_HOST_ADDR_WIDTH;

	localparam logic [`DMA_SIZE_WIDTH-1:0] WRITE_LIMIT = 1 << `DMA_LOG2_MAX_PAYLOAD;
	localparam logic [`DMA_SIZE_WIDTH-1:0] READ_LIMIT  = 1 << `DMA_LOG2_MAX_READ_REQUEST;

	dma_pkg::split_state_e state;

	logic [`DMA_HOST_ADDR_WIDTH-1:0] cur_addr;   // Address of the pending request
	logic [`DMA_SIZE_WIDTH-1:0]      remaining;
	logic [`DMA_SIZE_WIDTH-1:0]      limit;
	dma_pkg::dir_e                   dir;
	logic                            accept;

	////////////////////////////////////////////////////////////////////////////
	// Request outputs
	////////////////////////////////////////////////////////////////////////////

	assign limit     = (dir == dma_pkg::DIR_WRITE) ? WRITE_LIMIT : READ_LIMIT;
	assign req_len   = (remaining < limit) ? remaining : limit;
	assign req_addr  = cur_addr;
	assign req_dir   = dir;
	assign req_valid = (state == dma_pkg::ST_ISSUE) && (remaining != '0);
	assign accept    = req_valid & req_ready;

	assign busy = (state != dma_pkg::ST_IDLE);  // Covers issue and done
	assign done = (state == dma_pkg::ST_DONE);

	// FSM and request counter
	always_ff @(posedge CLK) begin
		if (!engine_reset_n) begin
			state     <= dma_pkg::ST_IDLE;
			req_count <= '0;
		end else begin
			case (state)
				dma_pkg::ST_IDLE: begin
					if (start) begin
						req_count <= '0;
						// Empty descriptor finishes without a request
						state <= (desc_size == '0) ? dma_pkg::ST_DONE : dma_pkg::ST_ISSUE;
					end
				end
				dma_pkg::ST_ISSUE: begin
					if (accept)
						req_count <= req_count + 1'b1;
					if (remaining == '0)
						state <= dma_pkg::ST_DONE;  // One cycle after the last transfer
				end
				dma_pkg::ST_DONE: begin
					state <= dma_pkg::ST_IDLE;
				end
				default: state <= dma_pkg::ST_IDLE;
			endcase
		end
	end

	// Descriptor latch and progress, only moves on a transfer
	always_ff @(posedge CLK) begin
		if (state == dma_pkg::ST_IDLE && start) begin
			cur_addr  <= desc_addr;
			remaining <= desc_size;
			dir       <= desc_dir;
		end else if (accept) begin
			cur_addr  <= cur_addr + HOST_W'(req_len);
			remaining <= remaining - req_len;
		end
	end

endmodule

`default_nettype wire

// File: dma_logic.sv
// DMA control core top level
// Wishbone register access, request port and engine reset combine

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_logic (
	input  logic                            CLK,
	input  logic                            dma_reset_n,
	input  logic                            wb_cyc,
	input  logic                            wb_stb,
	input  logic                            wb_we,
	input  logic [`DMA_ADDR_WIDTH-1:0]      wb_adr,
	input  logic [`DMA_DATA_WIDTH-1:0]      wb_dat_i,
	input  logic [`DMA_SEL_WIDTH-1:0]       wb_sel,
	input  logic                            req_ready,
	output logic [`DMA_DATA_WIDTH-1:0]      wb_dat_o,
	output logic                            wb_ack,
	output logic                            req_valid,
	output logic [`DMA_HOST_ADDR_WIDTH-1:0] req_addr,
	output logic [`DMA_SIZE_WIDTH-1:0]      req_len,
	output logic                            req_dir,
	output logic                            operation_in_course
);

	logic                            glb_ack;
	logic [`DMA_DATA_WIDTH-1:0]      glb_dat;
	logic                            eng_ack;
	logic [`DMA_DATA_WIDTH-1:0]      eng_dat;
	logic                            soft_reset_n;
	logic                            engine_reset_n;

	logic                            start;
	logic [`DMA_HOST_ADDR_WIDTH-1:0] desc_addr;
	logic [`DMA_SIZE_WIDTH-1:0]      desc_size;
	dma_pkg::dir_e                   desc_dir;
	logic                            busy;
	logic                            done;
	logic [`DMA_DATA_WIDTH-1:0]      req_count;

	assign engine_reset_n = dma_reset_n & soft_reset_n;  // Soft reset spares the global block

	////////////////////////////////////////////////////////////////////////////
	// Register slaves
	////////////////////////////////////////////////////////////////////////////

	dma_global_regs i_global_regs (
		.CLK          (CLK),
		.dma_reset_n  (dma_reset_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_sel       (wb_sel),
		.ack          (glb_ack),
		.dat          (glb_dat),
		.soft_reset_n (soft_reset_n)
	);

	dma_engine_regs i_engine_regs (
		.CLK            (CLK),
		.engine_reset_n (engine_reset_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_i       (wb_dat_i),
		.wb_sel         (wb_sel),
		.busy           (busy),
		.done           (done),
		.req_count      (req_count),
		.ack            (eng_ack),
		.dat            (eng_dat),
		.start          (start),
		.desc_addr      (desc_addr),
		.desc_size      (desc_size),
		.desc_dir       (desc_dir)
	);

	// Address windows are disjoint so at most one ack fires
	assign wb_ack   = glb_ack | eng_ack;
	assign wb_dat_o = glb_ack ? glb_dat : eng_dat;

	dma_request_splitter i_splitter (
		.CLK            (CLK),
		.engine_reset_n (engine_reset_n),
		.start          (start),
		.desc_addr      (desc_addr),
		.desc_size      (desc_size),
		.desc_dir       (desc_dir),
		.req_ready      (req_ready),
		.req_valid      (req_valid),
		.req_addr       (req_addr),
		.req_len        (req_len),
		.req_dir        (req_dir),
		.busy           (busy),
		.done           (done),
		.req_count      (req_count)
	);

	assign operation_in_course = busy;

endmodule

`default_nettype wire

// File: dma_properties.sv
// DMA control core assertions
// Wishbone ack shape and request port stability

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_properties (
	input wire logic        CLK,
	input wire logic        dma_reset_n,
	input wire logic        engine_reset_n,
	input wire logic        wb_ack,
	input wire logic        req_valid,
	input wire logic        req_ready,
	input wire logic [31:0] req_addr,
	input wire logic [31:0] req_len,
	input wire logic        req_dir,
	input wire logic        operation_in_course
);

	a_ack_single: assert property (@(posedge CLK) disable iff (!dma_reset_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high two cycles in a row");

	// A soft reset may drop a stalled request
	a_req_hold: assert property (@(posedge CLK) disable iff (!dma_reset_n)
		engine_reset_n && req_valid && !req_ready |=>
			req_valid && $stable(req_addr) && $stable(req_len) && $stable(req_dir))
		else $error("stalled request changed");

	a_valid_busy: assert property (@(posedge CLK) disable iff (!dma_reset_n)
		req_valid |-> operation_in_course)
		else $error("req_valid without operation_in_course");

endmodule

bind dma_logic dma_properties i_properties (
	.CLK                 (CLK),
	.dma_reset_n         (dma_reset_n),
	.engine_reset_n      (engine_reset_n),
	.wb_ack              (wb_ack),
	.req_valid           (req_valid),
	.req_ready           (req_ready),
	.req_addr            (req_addr),
	.req_len             (req_len),
	.req_dir             (req_dir),
	.operation_in_course (operation_in_course)
);

`default_nettype wire

// File: dma_checker.sv
// DMA control core checker
// Snoops Wishbone writes, predicts requests and register reads,
// and compares them with what the DUT does

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_checker (
	input wire logic        CLK,
	input wire logic        dma_reset_n,
	input wire logic        wb_cyc,
	input wire logic        wb_stb,
	input wire logic        wb_we,
	input wire logic [15:0] wb_adr,
	input wire logic [31:0] wb_dat_i,
	input wire logic [3:0]  wb_sel,
	input wire logic        wb_ack,
	input wire logic [31:0] wb_dat_o,
	input wire logic        req_valid,
	input wire logic        req_ready,
	input wire logic [31:0] req_addr,
	input wire logic [31:0] req_len,
	input wire logic        req_dir,
	input wire logic        operation_in_course
);

	localparam logic [15:0] ENG_LO = `DMA_ENGINE_BASE;
	localparam logic [15:0] ENG_HI = `DMA_ENGINE_BASE + `DMA_ENGINE_STRIDE;
	localparam logic [15:0] GLB    = `DMA_GLOBAL_ADDR;

	// Model of the engine registers
	logic [31:0] m_addr;
	logic [31:0] m_size;
	logic        m_dir;
	logic        m_busy;
	logic        m_stopped;
	logic [31:0] m_count;

	logic [31:0] exp_addr [$];
	logic [31:0] exp_len  [$];
	logic        exp_dir;

	logic        ack_pending;  // Bus cycle started on the previous edge
	logic        rd_pending;
	logic [31:0] rd_expect;

	string test_name;
	int    test_errors;
	int    error_count;
	int    tests_run;
	int    tests_failed;

	initial begin
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_errors  = 0;
		ack_pending  = 1'b0;
		rd_pending   = 1'b0;
	end

	task automatic record_error();
		test_errors++;
		error_count++;
	endtask

	task automatic clear_model();
		m_addr    = '0;
		m_size    = '0;
		m_dir     = 1'b0;
		m_busy    = 1'b0;
		m_stopped = 1'b0;
		m_count   = '0;
		exp_addr.delete();
		exp_len.delete();
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				res[8*b +: 8] = dat[8*b +: 8];
		return res;
	endfunction

	function automatic logic [31:0] predict_read(input logic [15:0] adr);
		logic [15:0] off;
		off = adr - ENG_LO;
		if (adr == GLB)
			return 32'h0000_0029;  // Read-request code 5, payload code 1
		if (adr < ENG_LO || adr >= ENG_HI || off[15:8] != 8'h00)
			return '0;
		case (off[7:0])
			dma_pkg::REG_CONTROL:   return {30'd0, m_dir, 1'b0};
			dma_pkg::REG_STATUS:    return {28'd0, m_stopped, 2'b00, m_busy};
			dma_pkg::REG_DESC_ADDR: return m_addr;
			dma_pkg::REG_DESC_SIZE: return m_size;
			dma_pkg::REG_REQ_COUNT: return m_count;
			default:                return '0;
		endcase
	endfunction

	// Builds the expected request list from the latched descriptor
	task automatic start_transfer();
		logic [31:0] limit;
		logic [31:0] left;
		logic [31:0] a;
		limit   = (m_dir == dma_pkg::DIR_WRITE) ? 32'd256 : 32'd4096;
		left    = m_size;
		a       = m_addr;
		exp_dir = m_dir;
		m_count = '0;
		m_stopped = 1'b0;
		exp_addr.delete();
		exp_len.delete();
		while (left != 0) begin
			exp_addr.push_back(a);
			exp_len.push_back(left < limit ? left : limit);
			a    = a + limit;
			left = left - (left < limit ? left : limit);
		end
		m_busy = (exp_addr.size() != 0);
		if (!m_busy)
			m_stopped = 1'b1;  // Empty descriptor stops at once
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitor samples values from before the edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		if (!dma_reset_n) begin
			clear_model();
			ack_pending = 1'b0;
			rd_pending  = 1'b0;
		end else begin
			if (ack_pending) begin
				ack_pending = 1'b0;
				if (wb_ack !== 1'b1) begin
					$display("** Error: wb_ack got 0x%h expected 0x1", wb_ack);
					record_error();
				end
			end
			if (rd_pending) begin
				rd_pending = 1'b0;
				if (wb_dat_o !== rd_expect) begin
					$display("** Error: wb_dat_o got 0x%h expected 0x%h", wb_dat_o, rd_expect);
					record_error();
				end
			end
			if (req_valid && req_ready) begin
				if (exp_addr.size() == 0) begin
					$display("%s: request at 0x%h accepted when none was expected",
						test_name, req_addr);
					record_error();
				end else begin
					if (req_addr !== exp_addr[0]) begin
						$display("** Error: req_addr got 0x%h expected 0x%h", req_addr, exp_addr[0]);
						record_error();
					end
					if (req_len !== exp_len[0]) begin
						$display("** Error: req_len got 0x%h expected 0x%h", req_len, exp_len[0]);
						record_error();
					end
					if (req_dir !== exp_dir) begin
						$display("** Error: req_dir got 0x%h expected 0x%h", req_dir, exp_dir);
						record_error();
					end
					void'(exp_addr.pop_front());
					void'(exp_len.pop_front());
					m_count = m_count + 1;
					if (exp_addr.size() == 0) begin
						m_busy    = 1'b0;
						m_stopped = 1'b1;
					end
				end
			end
			if (wb_cyc && wb_stb && !wb_ack) begin
				ack_pending = 1'b1;
				if (!wb_we) begin
					rd_expect  = predict_read(wb_adr);
					rd_pending = 1'b1;
				end else if (wb_adr == GLB) begin
					if (wb_sel[0] && wb_dat_i[7])
						clear_model();  // Engine soft reset
				end else if (wb_adr == ENG_LO + 16'h08) begin
					m_addr = merge_bytes(m_addr, wb_dat_i, wb_sel);
				end else if (wb_adr == ENG_LO + 16'h0C) begin
					m_size = merge_bytes(m_size, wb_dat_i, wb_sel);
				end else if (wb_adr == ENG_LO && wb_sel[0]) begin
					m_dir = wb_dat_i[1];
					if (wb_dat_i[0] && !m_busy)
						start_transfer();
				end
			end
		end
	end

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (exp_addr.size() != 0) begin
			$display("%s: %0d expected requests never arrived", test_name, exp_addr.size());
			record_error();
		end
		if (operation_in_course !== 1'b0) begin
			$display("** Error: operation_in_course got 0x%h expected 0x0", operation_in_course);
			record_error();
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, test_errors);
		end
	endtask

	task automatic report();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
	endtask

endmodule

`default_nettype wire

// File: tb_dma_logic.sv
// DMA control core testbench
// Programs descriptors over Wishbone from a stimulus table and
// applies random back-pressure on the request port

`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module tb_dma_logic;

	localparam logic [15:0] ENG_BASE = `DMA_ENGINE_BASE;
	localparam logic [15:0] GLB_ADDR = `DMA_GLOBAL_ADDR;
	localparam int NUM_ROWS = 4;

	typedef struct {
		string       name;
		logic [31:0] addr;
		logic [31:0] size;
		logic        dir;
		int          reset_after;  // -1 runs to completion
	} row_t;

	logic        CLK;
	logic        dma_reset_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [15:0] wb_adr;
	logic [31:0] wb_dat_i;
	logic [3:0]  wb_sel;
	logic        req_ready;
	logic [31:0] wb_dat_o;
	logic        wb_ack;
	logic        req_valid;
	logic [31:0] req_addr;
	logic [31:0] req_len;
	logic        req_dir;
	logic        operation_in_course;

	row_t rows [NUM_ROWS];
	logic hold_ready;
	int   accepted;
	int   cycles;
	int   cycle_limit;

	dma_logic i_dut (.*);

	dma_checker i_checker (.*);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	// Random stall pattern, about one cycle in four
	always @(negedge CLK) begin
		if (hold_ready)
			req_ready = 1'b0;
		else
			req_ready = ($urandom % 4) != 0;
	end

	always @(posedge CLK) begin
		if (req_valid && req_ready)
			accepted <= accepted + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Run limit
	////////////////////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat,
			input logic [3:0] sel);
		@(negedge CLK);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_i = dat;
		wb_sel   = sel;
		do @(negedge CLK); while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	// Data is compared by the checker
	task automatic wb_read(input logic [15:0] adr);
		@(negedge CLK);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wb_sel = 4'hF;
		do @(negedge CLK); while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic run_row(input row_t r);
		i_checker.begin_test(r.name);
		accepted   = 0;
		hold_ready = 1'b0;
		wb_write(ENG_BASE + 16'h08, r.addr, 4'hF);
		wb_write(ENG_BASE + 16'h0C, r.size, 4'hF);
		wb_write(ENG_BASE + 16'h00, {30'd0, r.dir, 1'b1}, 4'h1);
		if (r.reset_after < 0) begin
			while (!operation_in_course) @(negedge CLK);
			while (operation_in_course) @(negedge CLK);
		end else begin
			while (accepted < r.reset_after) @(negedge CLK);
			hold_ready = 1'b1;
			req_ready  = 1'b0;
			wb_write(GLB_ADDR, 32'h0000_0080, 4'h1);
			repeat (4) @(negedge CLK);
			hold_ready = 1'b0;
			repeat (12) @(negedge CLK);  // Room for any stray request
		end
		wb_read(ENG_BASE + 16'h04);
		wb_read(ENG_BASE + 16'h10);
		repeat (2) @(negedge CLK);
		i_checker.end_test();
	endtask

	initial begin
		void'($urandom(88800));
		dma_reset_n = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_i    = '0;
		wb_sel      = '0;
		req_ready   = 1'b0;
		hold_ready  = 1'b1;
		accepted    = 0;
		cycles      = 0;

		rows[0] = '{"write_1000", 32'h1000_0000, 32'd1000, 1'b1, -1};
		rows[1] = '{"read_10000", 32'h2000_0000, 32'd10000, 1'b0, -1};
		rows[2] = '{"size_zero", 32'h3000_0000, 32'd0, 1'b1, -1};
		rows[3] = '{"soft_reset", 32'h4000_0000, 32'd65536, 1'b0, 2};

		// 40 cycles per row plus 8 per request at the 256 byte limit
		cycle_limit = 200;
		for (int i = 0; i < NUM_ROWS; i++)
			cycle_limit += 40 + 8 * int'((rows[i].size + 255) / 256);

		repeat (5) @(negedge CLK);
		dma_reset_n = 1'b1;

		i_checker.begin_test("reg_readback");
		wb_write(ENG_BASE + 16'h08, 32'hAABB_CCDD, 4'hF);
		wb_write(ENG_BASE + 16'h08, 32'h1122_3344, 4'b0101);  // Lanes 0 and 2 only
		wb_write(ENG_BASE + 16'h0C, 32'h0000_1234, 4'hF);
		wb_write(ENG_BASE + 16'h0C, 32'h5600_0000, 4'b1000);
		wb_read(ENG_BASE + 16'h08);
		wb_read(ENG_BASE + 16'h0C);
		wb_read(GLB_ADDR);
		wb_read(16'h0100);  // Unmapped
		repeat (2) @(negedge CLK);
		i_checker.end_test();

		for (int i = 0; i < NUM_ROWS; i++)
			run_row(rows[i]);

		i_checker.report();
		if (i_checker.error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
dma_pkg.sv
dma_global_regs.sv
dma_engine_regs.sv
dma_request_splitter.sv
dma_logic.sv
dma_properties.sv
dma_checker.sv
tb_dma_logic.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, write $(LOG), fail on TEST FAIL"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module tb_dma_logic -o sim_dma
	./obj_dir/sim_dma > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
